// File: mem_pkg.sv
package mem_pkg;

  localparam int LINE_WORDS = 4;  // Words per cache line

  typedef logic [31:0] data_t;
  typedef logic [19:0] vpn_t;
  typedef logic [7:0]  ppn_t;
  typedef logic [19:0] paddr_t;
  typedef logic [11:0] tag_t;       // paddr[19:8]
  typedef logic [7:0]  line_idx_t;

  typedef struct packed {
    vpn_t        vpn;
    logic [11:0] page_off;
  } vaddr_page_t;

  // Index and offset sit inside the page offset, so no aliasing
  typedef struct packed {
    vpn_t        vpn;
    line_idx_t   line_sel;
    logic [3:0]  byte_off;
  } vaddr_cache_t;

  typedef union packed {
    vaddr_page_t  page;
    vaddr_cache_t cache;
  } vaddr_u;

  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } access_size_t;

  // RISC-V mcause codes
  typedef enum logic [3:0] {
    LOAD_PAGE_FAULT  = 4'd13,
    STORE_PAGE_FAULT = 4'd15
  } excpt_cause_t;

endpackage

// File: xlate_if.sv
`timescale 1ns/1ns

interface xlate_if import mem_pkg::*; ();
  vpn_t vpn;
  logic lookup_en;
  logic hit;       // Valid one cycle after lookup_en
  ppn_t ppn;
  logic writable;

  modport control (
    output vpn, lookup_en,
    input  hit, ppn, writable
  );

  modport lookup (
    input  vpn, lookup_en,
    output hit, ppn, writable
  );
endinterface

// File: cache_if.sv
`timescale 1ns/1ns

interface cache_if import mem_pkg::*; ();
  logic                   rd_en;
  line_idx_t              rd_index;
  logic                   rd_valid;
  tag_t                   rd_tag;
  data_t [LINE_WORDS-1:0] rd_line;

  logic                   refill_en;
  line_idx_t              refill_index;
  logic [1:0]             refill_word_sel;
  data_t                  refill_data;
  tag_t                   refill_tag;

  logic                   wr_en;
  line_idx_t              wr_index;
  logic [1:0]             wr_word_sel;
  data_t                  wr_data;
  logic [3:0]             wr_strb;

  modport control (
    output rd_en, rd_index,
    output refill_en, refill_index, refill_word_sel, refill_data, refill_tag,
    output wr_en, wr_index, wr_word_sel, wr_data, wr_strb,
    input  rd_valid, rd_tag, rd_line
  );

  modport array (
    input  rd_en, rd_index,
    input  refill_en, refill_index, refill_word_sel, refill_data, refill_tag,
    input  wr_en, wr_index, wr_word_sel, wr_data, wr_strb,
    output rd_valid, rd_tag, rd_line
  );
endinterface

// File: dtlb.sv
`timescale 1ns/1ns

module dtlb import mem_pkg::*; #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    fill_en_i,
  input  vpn_t    fill_vpn_i,
  input  ppn_t    fill_ppn_i,
  input  logic    fill_writable_i,
  xlate_if.lookup xl
);

  localparam int PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0] valid_q;
  logic [TLB_ENTRIES-1:0] writable_q;
  vpn_t                   vpn_q [TLB_ENTRIES];
  ppn_t                   ppn_q [TLB_ENTRIES];
  logic [PTR_W-1:0]       rr_ptr_q;

  logic [TLB_ENTRIES-1:0] match;
  logic [TLB_ENTRIES-1:0] fill_match;
  logic [PTR_W-1:0]       fill_idx;
  ppn_t                   hit_ppn;
  logic                   hit_writable;

  logic hit_q;
  ppn_t ppn_out_q;
  logic writable_out_q;

  always_comb begin
    fill_idx     = rr_ptr_q;
    hit_ppn      = '0;
    hit_writable = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      match[i]      = valid_q[i] && (vpn_q[i] == xl.vpn);
      fill_match[i] = valid_q[i] && (vpn_q[i] == fill_vpn_i);
      if (fill_match[i]) fill_idx = PTR_W'(i);  // Refresh existing mapping
      if (match[i]) begin
        hit_ppn      = ppn_q[i];
        hit_writable = writable_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q  <= '0;
      rr_ptr_q <= '0;
    end else if (fill_en_i) begin
      valid_q[fill_idx] <= 1'b1;
      if (!(|fill_match)) begin
        rr_ptr_q <= (rr_ptr_q == PTR_W'(TLB_ENTRIES - 1)) ? '0 : rr_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_en_i) begin
      vpn_q[fill_idx]      <= fill_vpn_i;
      ppn_q[fill_idx]      <= fill_ppn_i;
      writable_q[fill_idx] <= fill_writable_i;
    end
  end

  // Registered lookup result
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      hit_q <= 1'b0;
    end else if (xl.lookup_en) begin
      hit_q          <= |match;
      ppn_out_q      <= hit_ppn;
      writable_out_q <= hit_writable;
    end
  end

  assign xl.hit      = hit_q;
  assign xl.ppn      = ppn_out_q;
  assign xl.writable = writable_out_q;

  // Fill replacement by vpn keeps entries unique
  a_one_match: assert property (@(posedge clk_i) disable iff (!rst_i)
    xl.lookup_en |-> $onehot0(match));

endmodule

// File: dcache_array.sv
`timescale 1ns/1ns

module dcache_array import mem_pkg::*; #(
  parameter int N_LINES = 16
) (
  input  logic   clk_i,
  input  logic   rst_i,
  cache_if.array ca
);

  localparam int IDX_W = $clog2(N_LINES);

  logic [N_LINES-1:0]     valid_q;
  tag_t                   tag_q  [N_LINES];
  data_t [LINE_WORDS-1:0] data_q [N_LINES];

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] rf_idx;
  logic [IDX_W-1:0] wr_idx;
  logic             rf_last;

  assign rd_idx  = ca.rd_index[IDX_W-1:0];
  assign rf_idx  = ca.refill_index[IDX_W-1:0];
  assign wr_idx  = ca.wr_index[IDX_W-1:0];
  assign rf_last = (ca.refill_word_sel == 2'(LINE_WORDS - 1));

  // Line is invalid while partly refilled
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else if (ca.refill_en) begin
      if (rf_last) valid_q[rf_idx] <= 1'b1;
      else if (ca.refill_word_sel == 2'd0) valid_q[rf_idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ca.refill_en) begin
      data_q[rf_idx][ca.refill_word_sel] <= ca.refill_data;
      if (rf_last) tag_q[rf_idx] <= ca.refill_tag;
    end
    if (ca.wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (ca.wr_strb[b]) data_q[wr_idx][ca.wr_word_sel][8*b +: 8] <= ca.wr_data[8*b +: 8];
      end
    end
  end

  // Synchronous read by virtual index
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ca.rd_valid <= 1'b0;
    end else if (ca.rd_en) begin
      ca.rd_valid <= valid_q[rd_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (ca.rd_en) begin
      ca.rd_tag  <= tag_q[rd_idx];
      ca.rd_line <= data_q[rd_idx];
    end
  end

endmodule

// File: mem_ctrl.sv
`timescale 1ns/1ns

module mem_ctrl import mem_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         vm_en_i,
  input  logic         req_i,
  input  vaddr_u       vaddr_i,
  input  data_t        wdata_i,
  input  logic         is_store_i,
  input  access_size_t size_i,
  output logic         ack_o,
  output data_t        rdata_o,
  output logic         excpt_o,
  output excpt_cause_t cause_o,
  output logic         mem_req_o,
  output logic         mem_we_o,
  output paddr_t       mem_addr_o,
  output data_t        mem_wdata_o,
  output logic [3:0]   mem_strb_o,
  input  logic         mem_ack_i,
  input  data_t        mem_rdata_i,
  xlate_if.control     xl,
  cache_if.control     ca
);

  typedef enum logic [2:0] {IDLE, LOOKUP, DECIDE, REFILL, WRITE, ACK} state_t;

  state_t       state_q;
  logic         ack_q;
  logic         excpt_q;
  logic         mem_req_q;
  logic [1:0]   word_cnt_q;
  paddr_t       paddr_q;
  data_t        rdata_q;
  excpt_cause_t cause_q;

  paddr_t     paddr_d;
  logic       fault;
  logic       tag_hit;
  logic [1:0] word_sel;
  logic [3:0] base_strb;
  logic [3:0] store_strb;
  data_t      store_data;
  logic       mem_got_ack;
  logic       mem_released;

  assign word_sel = vaddr_i.cache.byte_off[3:2];
  assign paddr_d  = vm_en_i ? {xl.ppn, vaddr_i.page.page_off}
                            : {vaddr_i.page.vpn[7:0], vaddr_i.page.page_off};
  assign fault    = vm_en_i && (!xl.hit || (is_store_i && !xl.writable));
  assign tag_hit  = ca.rd_valid && (ca.rd_tag == paddr_d[19:8]);

  always_comb begin
    case (size_i)
      BYTE:    base_strb = 4'b0001;
      HALF:    base_strb = 4'b0011;
      default: base_strb = 4'b1111;
    endcase
  end

  assign store_strb   = base_strb << vaddr_i.cache.byte_off[1:0];
  assign store_data   = wdata_i << {vaddr_i.cache.byte_off[1:0], 3'b000};  // Byte lanes
  assign mem_got_ack  = mem_req_q && mem_ack_i;
  assign mem_released = !mem_req_q && !mem_ack_i;

  // TLB and array start together on the virtual address
  assign xl.lookup_en = (state_q == LOOKUP);
  assign xl.vpn       = vaddr_i.page.vpn;
  assign ca.rd_en     = (state_q == LOOKUP);
  assign ca.rd_index  = vaddr_i.cache.line_sel;

  assign ca.refill_en       = (state_q == REFILL) && mem_got_ack;
  assign ca.refill_index    = vaddr_i.cache.line_sel;
  assign ca.refill_word_sel = word_cnt_q;
  assign ca.refill_data     = mem_rdata_i;
  assign ca.refill_tag      = paddr_q[19:8];

  // Line updates at the edge where mem_req_o rises
  assign ca.wr_en       = (state_q == DECIDE) && is_store_i && !fault && tag_hit;
  assign ca.wr_index    = vaddr_i.cache.line_sel;
  assign ca.wr_word_sel = word_sel;
  assign ca.wr_data     = store_data;
  assign ca.wr_strb     = store_strb;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q    <= IDLE;
      ack_q      <= 1'b0;
      excpt_q    <= 1'b0;
      mem_req_q  <= 1'b0;
      word_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE:   if (req_i) state_q <= LOOKUP;
        LOOKUP: state_q <= DECIDE;
        DECIDE: begin
          word_cnt_q <= '0;
          if (fault) begin
            excpt_q <= 1'b1;
            ack_q   <= 1'b1;
            state_q <= ACK;
          end else if (is_store_i) begin
            mem_req_q <= 1'b1;  // Write through, hit or miss
            state_q   <= WRITE;
          end else if (tag_hit) begin
            ack_q   <= 1'b1;
            state_q <= ACK;
          end else begin
            mem_req_q <= 1'b1;
            state_q   <= REFILL;
          end
        end
        REFILL: begin
          if (mem_got_ack) begin
            mem_req_q <= 1'b0;
          end else if (mem_released) begin
            if (word_cnt_q == 2'(LINE_WORDS - 1)) begin
              ack_q   <= 1'b1;
              state_q <= ACK;
            end else begin
              word_cnt_q <= word_cnt_q + 2'd1;
              mem_req_q  <= 1'b1;
            end
          end
        end
        WRITE: begin
          if (mem_got_ack) begin
            mem_req_q <= 1'b0;
          end else if (mem_released) begin
            ack_q   <= 1'b1;
            state_q <= ACK;
          end
        end
        ACK: begin
          if (!req_i) begin
            ack_q   <= 1'b0;
            excpt_q <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == DECIDE) begin
      paddr_q <= paddr_d;
      cause_q <= is_store_i ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
      rdata_q <= (fault || is_store_i) ? '0 : ca.rd_line[word_sel];
    end else if (ca.refill_en && (word_cnt_q == word_sel)) begin
      rdata_q <= mem_rdata_i;  // Requested word on its way in
    end
  end

  assign ack_o       = ack_q;
  assign rdata_o     = rdata_q;
  assign excpt_o     = excpt_q;
  assign cause_o     = cause_q;
  assign mem_req_o   = mem_req_q;
  assign mem_we_o    = (state_q == WRITE);
  assign mem_addr_o  = (state_q == WRITE) ? {paddr_q[19:2], 2'b00}
                                          : {paddr_q[19:4], word_cnt_q, 2'b00};
  assign mem_wdata_o = store_data;
  assign mem_strb_o  = (state_q == WRITE) ? store_strb : 4'b0000;

  // Request and address held until memory answers
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o));

endmodule

// File: mem_stage.sv
`timescale 1ns/1ns

module mem_stage import mem_pkg::*; #(
  parameter int N_LINES     = 16,
  parameter int TLB_ENTRIES = 4
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         vm_en_i,
  input  logic         req_i,
  input  vaddr_u       vaddr_i,
  input  data_t        wdata_i,
  input  logic         is_store_i,
  input  access_size_t size_i,
  output logic         ack_o,
  output data_t        rdata_o,
  output logic         excpt_o,
  output excpt_cause_t cause_o,
  input  logic         fill_en_i,
  input  vpn_t         fill_vpn_i,
  input  ppn_t         fill_ppn_i,
  input  logic         fill_writable_i,
  output logic         mem_req_o,
  output logic         mem_we_o,
  output paddr_t       mem_addr_o,
  output data_t        mem_wdata_o,
  output logic [3:0]   mem_strb_o,
  input  logic         mem_ack_i,
  input  data_t        mem_rdata_i
);

  xlate_if xl_if ();
  cache_if ca_if ();

  dtlb #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) u_dtlb (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fill_en_i       (fill_en_i),
    .fill_vpn_i      (fill_vpn_i),
    .fill_ppn_i      (fill_ppn_i),
    .fill_writable_i (fill_writable_i),
    .xl              (xl_if)
  );

  dcache_array #(
    .N_LINES(N_LINES)
  ) u_dcache_array (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .ca    (ca_if)
  );

  mem_ctrl u_mem_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .vm_en_i     (vm_en_i),
    .req_i       (req_i),
    .vaddr_i     (vaddr_i),
    .wdata_i     (wdata_i),
    .is_store_i  (is_store_i),
    .size_i      (size_i),
    .ack_o       (ack_o),
    .rdata_o     (rdata_o),
    .excpt_o     (excpt_o),
    .cause_o     (cause_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_strb_o  (mem_strb_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .xl          (xl_if),
    .ca          (ca_if)
  );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Active low, released just after a rising edge
  initial begin
    rst_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b1;
  end

endmodule

// File: mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb import mem_pkg::*; ();

  localparam int MAX_STEPS = 64;

  logic         clk_i;
  logic         rst_i;
  logic         vm_en_i;
  logic         req_i;
  vaddr_u       vaddr_i;
  data_t        wdata_i;
  logic         is_store_i;
  access_size_t size_i;
  logic         ack_o;
  data_t        rdata_o;
  logic         excpt_o;
  excpt_cause_t cause_o;
  logic         fill_en_i;
  vpn_t         fill_vpn_i;
  ppn_t         fill_ppn_i;
  logic         fill_writable_i;
  logic         mem_req_o;
  logic         mem_we_o;
  paddr_t       mem_addr_o;
  data_t        mem_wdata_o;
  logic [3:0]   mem_strb_o;
  logic         mem_ack_i = 1'b0;
  data_t        mem_rdata_i = '0;

  // Trace contents
  string       op_a [MAX_STEPS];
  logic [31:0] addr_a [MAX_STEPS];
  logic [31:0] data_a [MAX_STEPS];
  logic [31:0] size_a [MAX_STEPS];
  logic [31:0] exp_data_a [MAX_STEPS];
  logic [31:0] exp_fault_a [MAX_STEPS];
  logic [31:0] exp_cause_a [MAX_STEPS];
  logic [31:0] rd_a [MAX_STEPS];
  logic [31:0] wr_a [MAX_STEPS];
  int          n_steps = 0;

  data_t       mem_model [paddr_t];
  ppn_t        ppn_map [vpn_t];   // Mappings filled so far
  paddr_t      rd_addrs [$];
  paddr_t      last_wr_addr;
  logic [3:0]  last_wr_strb;
  int          rd_count = 0;
  int          wr_count = 0;
  int          wait_cnt = 0;
  logic [31:0] rng_q = 32'hab13_2da3;
  logic [1:0]  mem_delay;

  int error_count = 0;
  int n_tests = 0;
  int n_failed = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;

  tb_clock #(.PERIOD_NS(40), .RST_CYCLES(2)) u_clock (.clk_o(clk_i), .rst_o(rst_i));

  mem_stage #(
    .N_LINES     (16),
    .TLB_ENTRIES (4)
  ) UUT (
    .clk_i (clk_i), .rst_i (rst_i), .vm_en_i (vm_en_i),
    .req_i (req_i), .vaddr_i (vaddr_i), .wdata_i (wdata_i),
    .is_store_i (is_store_i), .size_i (size_i),
    .ack_o (ack_o), .rdata_o (rdata_o), .excpt_o (excpt_o), .cause_o (cause_o),
    .fill_en_i (fill_en_i), .fill_vpn_i (fill_vpn_i), .fill_ppn_i (fill_ppn_i),
    .fill_writable_i (fill_writable_i),
    .mem_req_o (mem_req_o), .mem_we_o (mem_we_o), .mem_addr_o (mem_addr_o),
    .mem_wdata_o (mem_wdata_o), .mem_strb_o (mem_strb_o),
    .mem_ack_i (mem_ack_i), .mem_rdata_i (mem_rdata_i)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t read_word(input paddr_t a);
    return mem_model.exists(a) ? mem_model[a] : {12'ha5c, a};  // Untouched words
  endfunction

  function automatic paddr_t phys_addr(input logic [31:0] va);
    if (vm_en_i && ppn_map.exists(va[31:12])) return {ppn_map[va[31:12]], va[11:0]};
    return va[19:0];
  endfunction

  // One strobe bit per byte that the access touches
  function automatic logic [3:0] expected_strobe(input logic [1:0] size, input logic [1:0] off);
    logic [3:0] lanes;
    int         n_bytes;
    n_bytes = 1 << size;  // 1, 2 or 4 bytes
    lanes   = '0;
    for (int b = 0; b < 4; b++) begin
      lanes[b] = (b >= int'(off)) && (b < int'(off) + n_bytes);
    end
    return lanes;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic serve_access();
    data_t word;
    word = read_word(mem_addr_o);
    if (mem_we_o) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_strb_o[b]) word[8*b +: 8] = mem_wdata_o[8*b +: 8];
      end
      mem_model[mem_addr_o] = word;
      last_wr_addr = mem_addr_o;
      last_wr_strb = mem_strb_o;
      wr_count++;
    end else begin
      mem_rdata_i <= word;
      rd_addrs.push_back(mem_addr_o);
      rd_count++;
    end
  endtask

  assign mem_delay = rng_q[30:29];  // 0 to 3 cycles

  // Memory model, four-phase
  always @(posedge clk_i) begin
    if (!rst_i) begin
      mem_ack_i <= 1'b0;
      wait_cnt  <= 0;
    end else if (mem_req_o && !mem_ack_i) begin
      if (wait_cnt == mem_delay) begin
        serve_access();
        mem_ack_i <= 1'b1;
        wait_cnt  <= 0;
        rng_q     <= lcg_next(rng_q);
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end else if (!mem_req_o && mem_ack_i) begin
      mem_ack_i <= 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the trace did not finish within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic load_trace();
    int          fd;
    int          cnt;
    string       line;
    string       op;
    logic [31:0] f [8];
    fd = $fopen("mem_stage_trace.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && n_steps < MAX_STEPS) begin
        line = "";
        cnt = $fgets(line, fd);
        cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                      op, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        if (cnt == 9 && op != "#") begin
          op_a[n_steps]        = op;
          addr_a[n_steps]      = f[0];
          data_a[n_steps]      = f[1];
          size_a[n_steps]      = f[2];
          exp_data_a[n_steps]  = f[3];
          exp_fault_a[n_steps] = f[4];
          exp_cause_a[n_steps] = f[5];
          rd_a[n_steps]        = f[6];
          wr_a[n_steps]        = f[7];
          n_steps++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_fill(input int k);
    fill_en_i       <= 1'b1;
    fill_vpn_i      <= addr_a[k][19:0];
    fill_ppn_i      <= data_a[k][7:0];
    fill_writable_i <= size_a[k][0];
    ppn_map[addr_a[k][19:0]] = data_a[k][7:0];
    @(posedge clk_i);
    fill_en_i <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic run_access(input int k);
    int     rd_start;
    int     wr_start;
    int     err_start;
    logic   store;
    paddr_t pa;
    data_t  got_data;
    logic   got_fault;
    logic [3:0] got_cause;
    string  label;
    rd_start  = rd_count;
    wr_start  = wr_count;
    err_start = error_count;
    store     = (op_a[k] == "ST");
    pa        = phys_addr(addr_a[k]);
    label     = $sformatf("test %0d", n_tests + 1);
    rd_addrs.delete();
    req_i      <= 1'b1;
    vaddr_i    <= addr_a[k];
    wdata_i    <= data_a[k];
    is_store_i <= store;
    size_i     <= access_size_t'(size_a[k][1:0]);
    do @(posedge clk_i); while (ack_o !== 1'b1);
    got_data  = rdata_o;
    got_fault = excpt_o;
    got_cause = cause_o;
    req_i <= 1'b0;
    do @(posedge clk_i); while (ack_o !== 1'b0);

    check_value({label, " excpt_o"}, 32'(got_fault), exp_fault_a[k]);
    if (exp_fault_a[k][0]) check_value({label, " cause_o"}, 32'(got_cause), exp_cause_a[k]);
    if (!store && !exp_fault_a[k][0]) check_value({label, " rdata_o"}, got_data, exp_data_a[k]);
    check_value({label, " memory reads"}, rd_count - rd_start, rd_a[k]);
    check_value({label, " memory writes"}, wr_count - wr_start, wr_a[k]);
    if (rd_a[k] == 4 && rd_addrs.size() == 4) begin
      for (int i = 0; i < 4; i++) begin  // Word order 0 to 3
        check_value($sformatf("%s refill address %0d", label, i),
                    32'(rd_addrs[i]), 32'({pa[19:4], 2'(i), 2'b00}));
      end
    end
    if (store && wr_a[k] == 1 && wr_count - wr_start == 1) begin
      check_value({label, " write address"}, 32'(last_wr_addr), 32'({pa[19:2], 2'b00}));
      check_value({label, " write strobe"}, 32'(last_wr_strb),
                  32'(expected_strobe(size_a[k][1:0], addr_a[k][1:0])));
    end
    n_tests++;
    if (error_count != err_start) n_failed++;
    $display("%s %s %h: %s", label, op_a[k], addr_a[k],
             (error_count == err_start) ? "ok" : "mismatch");
  endtask

  initial begin
    vm_en_i         = 1'b1;
    req_i           = 1'b0;
    vaddr_i         = '0;
    wdata_i         = '0;
    is_store_i      = 1'b0;
    size_i          = WORD;
    fill_en_i       = 1'b0;
    fill_vpn_i      = '0;
    fill_ppn_i      = '0;
    fill_writable_i = 1'b0;
    load_trace();
    cycle_limit = n_steps * 40;
    if (n_steps == 0) begin
      $display("No operations could be read from mem_stage_trace.txt");
      $display("Finished with errors");
      $finish;
    end else begin
      wait (rst_i === 1'b1);
      @(posedge clk_i);
      for (int k = 0; k < n_steps; k++) begin
        if (op_a[k] == "FILL") begin
          apply_fill(k);
        end else if (op_a[k] == "MODE") begin
          vm_en_i <= addr_a[k][0];
          @(posedge clk_i);
        end else if (op_a[k] == "LD" || op_a[k] == "ST") begin
          run_access(k);
        end else begin
          $display("Unknown operation %s in the trace", op_a[k]);
          error_count++;
        end
      end
      $display("%0d tests, %0d passed, %0d failed", n_tests, n_tests - n_failed, n_failed);
      if (error_count == 0) begin
        $display("Finished with no errors");
      end else begin
        $display("Finished with errors");
      end
      $finish;
    end
  end

endmodule

// File: mem_stage.f
mem_pkg.sv
xlate_if.sv
cache_if.sv
dtlb.sv
dcache_array.sv
mem_ctrl.sv
mem_stage.sv
tb_clock.sv
mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - mem_pkg.sv
  - xlate_if.sv
  - cache_if.sv
  - dtlb.sv
  - dcache_array.sv
  - mem_ctrl.sv
  - mem_stage.sv
  - target: test
    files:
      - tb_clock.sv
      - mem_stage_tb.sv

// File: mem_stage_trace.txt
# op addr data size(0 byte,1 half,2 word) exp_data fault cause reads writes, all hex
# For FILL addr is the vpn, data the ppn, size the writable bit; MODE takes vm_en from addr
FILL 00010    12       1  0        0  0  0  0
FILL 00020    34       0  0        0  0  0  0
LD   00010124 0        2  a5c12124 0  0  4  0
LD   00010124 0        2  a5c12124 0  0  0  0
ST   00010125 ee       0  0        0  0  0  1
ST   00010126 1234     1  0        0  0  0  1
LD   00010124 0        2  1234ee24 0  0  0  0
ST   00010208 cafef00d 2  0        0  0  0  1
LD   00010208 0        2  cafef00d 0  0  4  0
ST   0001030b 5a       0  0        0  0  0  1
LD   00010308 0        2  5ac12308 0  0  4  0
LD   00055000 0        2  0        1  d  0  0
ST   00055004 11223344 2  0        1  f  0  0
ST   00020040 55667788 2  0        1  f  0  0
LD   00020040 0        2  a5c34040 0  0  4  0
LD   00020044 0        2  a5c34044 0  0  0  0
MODE 0        0        0  0        0  0  0  0
LD   00012124 0        2  1234ee24 0  0  0  0
LD   fff56788 0        2  a5c56788 0  0  4  0
ST   abc12128 beef     1  0        0  0  0  1
LD   00012128 0        2  a5c1beef 0  0  0  0
